// ==== design/wlast_rebuild_pkg.sv ====
`default_nettype none

package wlast_rebuild_pkg;

    // Four lanes, chosen by the two low bits of the write ID
    localparam int n_lanes = 4;
    localparam int lane_w = 2;

    // Channel field widths
    localparam int id_w = 4;
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = 4;

    // AXI length field holds the beat count minus one
    localparam int len_w = 8;

    // Write address as seen on both the source and the sink side
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;
    } wr_addr_t;

    // Source beat in the AXI3 style, tagged with its ID and without last
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
    } wr_beat_in_t;

    // Sink beat in the AXI4 style, with the rebuilt last flag
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } wr_beat_out_t;

    // Merger waits for an address in idle and stays locked on one lane in burst
    typedef enum logic [0:0] {
        merge_idle,
        merge_burst
    } merge_state_e;

endpackage

`default_nettype wire

// ==== design/wr_lane_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module wr_lane_dispatch (
    input  logic                                    clk,
    input  logic                                    rst,
    input  wlast_rebuild_pkg::wr_addr_t             s_aw,
    input  logic                                    s_aw_valid,
    output logic                                    s_aw_ready,
    input  wlast_rebuild_pkg::wr_beat_in_t          s_w,
    input  logic                                    s_w_valid,
    output logic                                    s_w_ready,
    output wlast_rebuild_pkg::wr_addr_t             lane_aw,
    output logic [wlast_rebuild_pkg::n_lanes-1:0]   lane_aw_valid,
    input  logic [wlast_rebuild_pkg::n_lanes-1:0]   lane_aw_ready,
    output wlast_rebuild_pkg::wr_beat_in_t          lane_w,
    output logic [wlast_rebuild_pkg::n_lanes-1:0]   lane_w_valid,
    input  logic [wlast_rebuild_pkg::n_lanes-1:0]   lane_w_ready
);

    // Held items and the lane each one was decoded to
    wlast_rebuild_pkg::wr_addr_t    aw_q;
    wlast_rebuild_pkg::wr_beat_in_t w_q;
    logic [wlast_rebuild_pkg::lane_w-1:0] aw_lane_q;
    logic [wlast_rebuild_pkg::lane_w-1:0] w_lane_q;
    logic aw_full_q;
    logic w_full_q;
    // Keeps both source readies low until the first cycle out of reset
    logic run_q;
    logic aw_take;
    logic w_take;

    // Only the target lane's ready decides whether the held item leaves
    assign aw_take = aw_full_q && lane_aw_ready[aw_lane_q];
    assign w_take = w_full_q && lane_w_ready[w_lane_q];

    // A new item fits when the register is empty or drains in this cycle
    assign s_aw_ready = run_q && (!aw_full_q || aw_take);
    assign s_w_ready = run_q && (!w_full_q || w_take);

    // One shared payload bus per channel, the valid picks the lane
    assign lane_aw = aw_q;
    assign lane_w = w_q;

    always_comb
    begin
        lane_aw_valid = '0;
        lane_w_valid = '0;
        lane_aw_valid[aw_lane_q] = aw_full_q;
        lane_w_valid[w_lane_q] = w_full_q;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            run_q <= 1'b0;
            aw_full_q <= 1'b0;
            w_full_q <= 1'b0;
        end
        else
        begin
            run_q <= 1'b1;
            // With ready high the register is free, so it simply takes valid
            if (s_aw_ready)
                aw_full_q <= s_aw_valid;
            if (s_w_ready)
                w_full_q <= s_w_valid;
        end
    end

    // Payload and lane select load only on a handshake
    always_ff @(posedge clk)
    begin
        if (s_aw_valid && s_aw_ready)
        begin
            aw_q <= s_aw;
            aw_lane_q <= s_aw.id[wlast_rebuild_pkg::lane_w-1:0];
        end
        if (s_w_valid && s_w_ready)
        begin
            w_q <= s_w;
            w_lane_q <= s_w.id[wlast_rebuild_pkg::lane_w-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== design/wlast_fixup_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module wlast_fixup_lane (
    input  logic                            clk,
    input  logic                            rst,
    input  wlast_rebuild_pkg::wr_addr_t     in_aw,
    input  logic                            in_aw_valid,
    output logic                            in_aw_ready,
    input  wlast_rebuild_pkg::wr_beat_in_t  in_w,
    input  logic                            in_w_valid,
    output logic                            in_w_ready,
    output wlast_rebuild_pkg::wr_addr_t     out_aw,
    output logic                            out_aw_valid,
    input  logic                            out_aw_ready,
    output wlast_rebuild_pkg::wr_beat_out_t out_w,
    output logic                            out_w_valid,
    input  logic                            out_w_ready
);

    // One-deep holding registers for the address and the data beat
    wlast_rebuild_pkg::wr_addr_t    aw_q;
    wlast_rebuild_pkg::wr_beat_in_t w_q;
    logic aw_full_q;
    logic w_full_q;

    // High while the next beat to issue opens a new burst
    logic sop_q;
    // Beats still to come after the one most recently issued
    logic [wlast_rebuild_pkg::len_w-1:0] cnt_q;

    logic aw_leave;
    logic w_leave;
    logic eop;

    // The address leaves only together with the first beat of its burst,
    // which keeps the AW and W streams aligned on the sink side
    assign out_aw_valid = aw_full_q && w_full_q && sop_q;

    // A first beat needs its address, middle and final beats go alone
    assign out_w_valid = w_full_q && (!sop_q || aw_full_q);

    assign aw_leave = out_aw_valid && out_aw_ready;
    assign w_leave = out_w_valid && out_w_ready;

    // A beat stuck waiting for its address blocks the data input
    assign in_aw_ready = !aw_full_q || aw_leave;
    assign in_w_ready = !w_full_q || w_leave;

    // On the first beat the length decides, afterwards the counter
    assign eop = sop_q ? (aw_q.len == '0) : (cnt_q == '0);

    assign out_aw = aw_q;

    // The ID is dropped here and the rebuilt last takes its place
    always_comb
    begin
        out_w.data = w_q.data;
        out_w.strb = w_q.strb;
        out_w.last = eop;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            aw_full_q <= 1'b0;
            w_full_q <= 1'b0;
            sop_q <= 1'b1;
            cnt_q <= '0;
        end
        else
        begin
            if (in_aw_ready)
                aw_full_q <= in_aw_valid;
            if (in_w_ready)
                w_full_q <= in_w_valid;
            if (w_leave)
            begin
                // The beat after a last one starts the next burst
                sop_q <= eop;
                // Load the length on the first beat, already less this beat
                if (sop_q)
                    cnt_q <= aw_q.len - 1'b1;
                else
                    cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_aw_valid && in_aw_ready)
            aw_q <= in_aw;
        if (in_w_valid && in_w_ready)
            w_q <= in_w;
    end

endmodule

`default_nettype wire

// ==== design/wr_burst_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module wr_burst_merge (
    input  logic                                  clk,
    input  logic                                  rst,
    input  wlast_rebuild_pkg::wr_addr_t           lane_aw [wlast_rebuild_pkg::n_lanes],
    input  logic [wlast_rebuild_pkg::n_lanes-1:0] lane_aw_valid,
    output logic [wlast_rebuild_pkg::n_lanes-1:0] lane_aw_ready,
    input  wlast_rebuild_pkg::wr_beat_out_t       lane_w [wlast_rebuild_pkg::n_lanes],
    input  logic [wlast_rebuild_pkg::n_lanes-1:0] lane_w_valid,
    output logic [wlast_rebuild_pkg::n_lanes-1:0] lane_w_ready,
    output wlast_rebuild_pkg::wr_addr_t           m_aw,
    output logic                                  m_aw_valid,
    input  logic                                  m_aw_ready,
    output wlast_rebuild_pkg::wr_beat_out_t       m_w,
    output logic                                  m_w_valid,
    input  logic                                  m_w_ready
);

    wlast_rebuild_pkg::merge_state_e state_q;
    // Search start for the next grant, and the lane that owns the output
    logic [wlast_rebuild_pkg::lane_w-1:0] ptr_q;
    logic [wlast_rebuild_pkg::lane_w-1:0] grant_q;
    logic [wlast_rebuild_pkg::lane_w-1:0] rr_pick;
    logic [wlast_rebuild_pkg::lane_w-1:0] sel;
    logic any_aw;
    logic active;
    logic sel_aw;
    logic pair_ok;
    logic burst_done;

    // First lane with a pending address, searching upward from the pointer
    always_comb
    begin
        logic [wlast_rebuild_pkg::lane_w-1:0] idx;
        rr_pick = ptr_q;
        any_aw = 1'b0;
        for (int k = 0; k < wlast_rebuild_pkg::n_lanes; k++)
        begin
            idx = ptr_q + k[wlast_rebuild_pkg::lane_w-1:0];
            if (!any_aw && lane_aw_valid[idx])
            begin
                rr_pick = idx;
                any_aw = 1'b1;
            end
        end
    end

    // In a burst only the granted lane may reach the output
    assign sel = (state_q == wlast_rebuild_pkg::merge_burst) ? grant_q : rr_pick;
    assign active = (state_q == wlast_rebuild_pkg::merge_burst) || any_aw;
    assign sel_aw = active && lane_aw_valid[sel];

    // Address and first beat move as one, so both readies must be high
    assign pair_ok = m_aw_ready && m_w_ready;

    assign m_aw = lane_aw[sel];
    assign m_w = lane_w[sel];
    assign m_aw_valid = sel_aw && pair_ok;
    assign m_w_valid = active && lane_w_valid[sel] && (!sel_aw || pair_ok);

    always_comb
    begin
        lane_aw_ready = '0;
        lane_w_ready = '0;
        if (active)
        begin
            lane_aw_ready[sel] = pair_ok;
            lane_w_ready[sel] = m_w_ready && (!sel_aw || m_aw_ready);
        end
    end

    assign burst_done = m_w_valid && m_w_ready && m_w.last;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= wlast_rebuild_pkg::merge_idle;
            ptr_q <= '0;
            grant_q <= '0;
        end
        else
        begin
            case (state_q)
                wlast_rebuild_pkg::merge_idle:
                begin
                    // Lock on the picked lane, unless a one-beat burst already left
                    if (any_aw)
                    begin
                        grant_q <= rr_pick;
                        ptr_q <= rr_pick + 1'b1;
                        if (!burst_done)
                            state_q <= wlast_rebuild_pkg::merge_burst;
                    end
                end
                wlast_rebuild_pkg::merge_burst:
                begin
                    if (burst_done)
                        state_q <= wlast_rebuild_pkg::merge_idle;
                end
                default:
                    state_q <= wlast_rebuild_pkg::merge_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/wlast_rebuild_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module wlast_rebuild_top (
    input  logic                            clk,
    input  logic                            rst,
    input  wlast_rebuild_pkg::wr_addr_t     s_aw,
    input  logic                            s_aw_valid,
    output logic                            s_aw_ready,
    input  wlast_rebuild_pkg::wr_beat_in_t  s_w,
    input  logic                            s_w_valid,
    output logic                            s_w_ready,
    output wlast_rebuild_pkg::wr_addr_t     m_aw,
    output logic                            m_aw_valid,
    input  logic                            m_aw_ready,
    output wlast_rebuild_pkg::wr_beat_out_t m_w,
    output logic                            m_w_valid,
    input  logic                            m_w_ready
);

    // Shared buses from the dispatcher into every lane
    wlast_rebuild_pkg::wr_addr_t    disp_aw;
    wlast_rebuild_pkg::wr_beat_in_t disp_w;
    logic [wlast_rebuild_pkg::n_lanes-1:0] disp_aw_valid;
    logic [wlast_rebuild_pkg::n_lanes-1:0] disp_aw_ready;
    logic [wlast_rebuild_pkg::n_lanes-1:0] disp_w_valid;
    logic [wlast_rebuild_pkg::n_lanes-1:0] disp_w_ready;

    // Per-lane outputs toward the merger
    wlast_rebuild_pkg::wr_addr_t    fix_aw [wlast_rebuild_pkg::n_lanes];
    wlast_rebuild_pkg::wr_beat_out_t fix_w [wlast_rebuild_pkg::n_lanes];
    logic [wlast_rebuild_pkg::n_lanes-1:0] fix_aw_valid;
    logic [wlast_rebuild_pkg::n_lanes-1:0] fix_aw_ready;
    logic [wlast_rebuild_pkg::n_lanes-1:0] fix_w_valid;
    logic [wlast_rebuild_pkg::n_lanes-1:0] fix_w_ready;

    wr_lane_dispatch wr_lane_dispatch_i (
        .clk           (clk),
        .rst           (rst),
        .s_aw          (s_aw),
        .s_aw_valid    (s_aw_valid),
        .s_aw_ready    (s_aw_ready),
        .s_w           (s_w),
        .s_w_valid     (s_w_valid),
        .s_w_ready     (s_w_ready),
        .lane_aw       (disp_aw),
        .lane_aw_valid (disp_aw_valid),
        .lane_aw_ready (disp_aw_ready),
        .lane_w        (disp_w),
        .lane_w_valid  (disp_w_valid),
        .lane_w_ready  (disp_w_ready)
    );

    // Each lane sees only the IDs that decode to it
    for (genvar i = 0; i < wlast_rebuild_pkg::n_lanes; i++)
    begin : g_lane
        wlast_fixup_lane wlast_fixup_lane_i (
            .clk          (clk),
            .rst          (rst),
            .in_aw        (disp_aw),
            .in_aw_valid  (disp_aw_valid[i]),
            .in_aw_ready  (disp_aw_ready[i]),
            .in_w         (disp_w),
            .in_w_valid   (disp_w_valid[i]),
            .in_w_ready   (disp_w_ready[i]),
            .out_aw       (fix_aw[i]),
            .out_aw_valid (fix_aw_valid[i]),
            .out_aw_ready (fix_aw_ready[i]),
            .out_w        (fix_w[i]),
            .out_w_valid  (fix_w_valid[i]),
            .out_w_ready  (fix_w_ready[i])
        );
    end

    wr_burst_merge wr_burst_merge_i (
        .clk           (clk),
        .rst           (rst),
        .lane_aw       (fix_aw),
        .lane_aw_valid (fix_aw_valid),
        .lane_aw_ready (fix_aw_ready),
        .lane_w        (fix_w),
        .lane_w_valid  (fix_w_valid),
        .lane_w_ready  (fix_w_ready),
        .m_aw          (m_aw),
        .m_aw_valid    (m_aw_valid),
        .m_aw_ready    (m_aw_ready),
        .m_w           (m_w),
        .m_w_valid     (m_w_valid),
        .m_w_ready     (m_w_ready)
    );

endmodule

`default_nettype wire

// ==== tb/wlast_rebuild_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module wlast_rebuild_tb;

    localparam int timeout_cycles = 2000;
    localparam logic [31:0] lfsr_seed = 32'hb3e5;
    localparam int max_bursts = 64;
    localparam int words = 5;

    logic clk;
    logic rst;
    wlast_rebuild_pkg::wr_addr_t     s_aw;
    logic                            s_aw_valid;
    logic                            s_aw_ready;
    wlast_rebuild_pkg::wr_beat_in_t  s_w;
    logic                            s_w_valid;
    logic                            s_w_ready;
    wlast_rebuild_pkg::wr_addr_t     m_aw;
    logic                            m_aw_valid;
    logic                            m_aw_ready;
    wlast_rebuild_pkg::wr_beat_out_t m_w;
    logic                            m_w_valid;
    logic                            m_w_ready;

    // Five words per burst: id, addr, len, data base, data-before-address flag
    logic [31:0] tdata [words*max_bursts];
    logic [31:0] lfsr;
    int n_bursts;
    // The oldest unfinished burst of each lane sits at the head of its queue
    int lane_q [wlast_rebuild_pkg::n_lanes][$];
    int beats_sent [max_bursts];
    int next_aw;
    int w_burst;
    bit aw_busy;
    bit w_busy;
    // Burst now open on the output and the index of its next beat
    int cur_out;
    int out_beat;
    int errors;
    int burst_errors;
    int bursts_ok;
    int bursts_bad;
    int done_bursts;
    int idle_cycles;

    wlast_rebuild_top wlast_rebuild_top_i (
        .clk        (clk),
        .rst        (rst),
        .s_aw       (s_aw),
        .s_aw_valid (s_aw_valid),
        .s_aw_ready (s_aw_ready),
        .s_w        (s_w),
        .s_w_valid  (s_w_valid),
        .s_w_ready  (s_w_ready),
        .m_aw       (m_aw),
        .m_aw_valid (m_aw_valid),
        .m_aw_ready (m_aw_ready),
        .m_w        (m_w),
        .m_w_valid  (m_w_valid),
        .m_w_ready  (m_w_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR, one step per random bit
    function automatic bit next_rand_bit();
        bit lsb;
        lsb = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb)
            lfsr = lfsr ^ 32'h8020_0003;
        return lsb;
    endfunction

    function automatic int burst_len(int b);
        return int'(tdata[words*b+2][wlast_rebuild_pkg::len_w-1:0]);
    endfunction

    function automatic int burst_lane(int b);
        return int'(tdata[words*b][wlast_rebuild_pkg::id_w-1:0]) % wlast_rebuild_pkg::n_lanes;
    endfunction

    function automatic bit data_first(int b);
        return tdata[words*b+4][0];
    endfunction

    function automatic logic [31:0] beat_data(int b, int k);
        return tdata[words*b+3] + 32'(k);
    endfunction

    function automatic wlast_rebuild_pkg::wr_addr_t burst_addr(int b);
        wlast_rebuild_pkg::wr_addr_t a;
        a.id = tdata[words*b][wlast_rebuild_pkg::id_w-1:0];
        a.addr = tdata[words*b+1];
        a.len = tdata[words*b+2][wlast_rebuild_pkg::len_w-1:0];
        return a;
    endfunction

    function automatic wlast_rebuild_pkg::wr_beat_in_t source_beat(int b, int k);
        wlast_rebuild_pkg::wr_beat_in_t w;
        w.id = tdata[words*b][wlast_rebuild_pkg::id_w-1:0];
        w.data = beat_data(b, k);
        w.strb = '1;
        return w;
    endfunction

    // Chooses the burst that supplies the next source beat, -1 when none may
    function automatic int pick_beat();
        int cand [$];
        int pick;
        int lane;
        pick = -1;
        for (int b = 0; b < n_bursts; b++)
        begin
            lane = burst_lane(b);
            // A first beat waits until the older bursts of its lane have left the output
            if (beats_sent[b] == 0)
            begin
                if (lane_q[lane].size() > 0 && lane_q[lane][0] == b
                    && (b < next_aw || data_first(b)))
                    cand.push_back(b);
            end
            // Later beats only follow a burst that is already open on the output
            else if (beats_sent[b] <= burst_len(b) && cur_out == b)
                cand.push_back(b);
        end
        foreach (cand[i])
            if (pick < 0 && (i == cand.size() - 1 || next_rand_bit()))
                pick = cand[i];
        return pick;
    endfunction

    task automatic note_error();
        errors++;
        if (cur_out >= 0)
            burst_errors++;
    endtask

    task automatic finish_burst();
        wlast_rebuild_pkg::wr_addr_t a;
        a = burst_addr(cur_out);
        void'(lane_q[burst_lane(cur_out)].pop_front());
        done_bursts++;
        if (burst_errors == 0)
            bursts_ok++;
        else
            bursts_bad++;
        $display("burst %0d id %h addr %h len %0d data first %0d: %s", cur_out, a.id,
                 a.addr, a.len, data_first(cur_out), (burst_errors == 0) ? "ok" : "mismatch");
        cur_out = -1;
    endtask

    // Runs mid cycle, so every handshake seen here completes at the next edge
    task automatic check_outputs();
        wlast_rebuild_pkg::wr_addr_t exp_aw;
        wlast_rebuild_pkg::wr_beat_out_t exp_w;
        int lane;
        idle_cycles++;
        assert (!m_aw_valid || m_w_valid)
        else
        begin
            $display("m_aw_valid is high without a first beat on m_w");
            note_error();
        end
        if (m_aw_valid && m_aw_ready)
        begin
            lane = int'(m_aw.id) % wlast_rebuild_pkg::n_lanes;
            assert (cur_out < 0)
            else
            begin
                $display("an address arrived while burst %0d was still open", cur_out);
                note_error();
            end
            assert (lane_q[lane].size() > 0)
            else
            begin
                $display("an address arrived for lane %0d with no burst left", lane);
                errors++;
            end
            if (lane_q[lane].size() > 0)
            begin
                cur_out = lane_q[lane][0];
                out_beat = 0;
                burst_errors = 0;
                exp_aw = burst_addr(cur_out);
                assert (m_aw == exp_aw)
                else
                begin
                    $display("CHECK FAILED m_aw got %h expected %h", m_aw, exp_aw);
                    note_error();
                end
            end
        end
        if (m_w_valid && m_w_ready)
        begin
            idle_cycles = 0;
            assert (cur_out >= 0)
            else
            begin
                $display("a beat left on m_w outside of any burst");
                errors++;
            end
            if (cur_out >= 0)
            begin
                exp_w.data = beat_data(cur_out, out_beat);
                exp_w.strb = '1;
                exp_w.last = (out_beat == burst_len(cur_out));
                assert (m_w == exp_w)
                else
                begin
                    $display("CHECK FAILED m_w got %h expected %h", m_w, exp_w);
                    note_error();
                end
                if (out_beat == burst_len(cur_out))
                    finish_burst();
                else
                    out_beat++;
            end
        end
        // Source side bookkeeping for the items taken at the coming edge
        if (aw_busy && s_aw_ready)
        begin
            next_aw++;
            aw_busy = 1'b0;
        end
        if (w_busy && s_w_ready)
        begin
            beats_sent[w_burst]++;
            w_busy = 1'b0;
        end
    endtask

    task automatic drive_inputs();
        bit send_aw;
        m_aw_ready <= next_rand_bit();
        m_w_ready <= next_rand_bit();
        if (!aw_busy)
        begin
            s_aw_valid <= 1'b0;
            if (next_aw < n_bursts)
            begin
                // A data-first burst holds its address back until its first beat is in
                if (data_first(next_aw))
                    send_aw = beats_sent[next_aw] > 0;
                else
                    send_aw = next_rand_bit();
                if (send_aw)
                begin
                    s_aw <= burst_addr(next_aw);
                    s_aw_valid <= 1'b1;
                    aw_busy = 1'b1;
                end
            end
        end
        if (!w_busy)
        begin
            s_w_valid <= 1'b0;
            w_burst = pick_beat();
            if (w_burst >= 0)
            begin
                s_w <= source_beat(w_burst, beats_sent[w_burst]);
                s_w_valid <= 1'b1;
                w_busy = 1'b1;
            end
        end
    endtask

    initial
    begin
        rst = 1'b1;
        s_aw = '0;
        s_aw_valid = 1'b0;
        s_w = '0;
        s_w_valid = 1'b0;
        m_aw_ready = 1'b0;
        m_w_ready = 1'b0;
        lfsr = lfsr_seed;
        errors = 0;
        burst_errors = 0;
        bursts_ok = 0;
        bursts_bad = 0;
        done_bursts = 0;
        idle_cycles = 0;
        next_aw = 0;
        w_burst = -1;
        cur_out = -1;
        out_beat = 0;
        aw_busy = 1'b0;
        w_busy = 1'b0;
        // Words never loaded keep a tag above any legal ID, which ends the list
        for (int i = 0; i < words*max_bursts; i++)
            tdata[i] = 32'hdead_0000 | 32'(i);
        $readmemh("tb/wlast_rebuild_testdata.hex", tdata);
        n_bursts = 0;
        while (n_bursts < max_bursts && tdata[words*n_bursts] < 32'h10)
            n_bursts++;
        for (int b = 0; b < n_bursts; b++)
        begin
            lane_q[burst_lane(b)].push_back(b);
            beats_sent[b] = 0;
        end
        assert (n_bursts > 0)
        else
        begin
            $display("no bursts were read from the data file");
            errors++;
        end

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Ends when every burst is out, or after a long stretch with no output beat
        while (done_bursts < n_bursts && idle_cycles < timeout_cycles)
        begin
            @(negedge clk);
            check_outputs();
            @(posedge clk);
            drive_inputs();
        end

        if (done_bursts < n_bursts)
        begin
            $display("timeout after %0d cycles without an output beat, %0d of %0d bursts done",
                     timeout_cycles, done_bursts, n_bursts);
            errors++;
        end
        for (int l = 0; l < wlast_rebuild_pkg::n_lanes; l++)
        begin
            assert (lane_q[l].size() == 0)
            else
            begin
                $display("lane %0d still expects %0d bursts", l, lane_q[l].size());
                errors++;
            end
        end
        $display("bursts passed %0d, bursts failed %0d, errors %0d",
                 bursts_ok, bursts_bad, errors);
        if (errors == 0 && bursts_bad == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== wlast_rebuild.f ====
design/wlast_rebuild_pkg.sv
design/wr_lane_dispatch.sv
design/wlast_fixup_lane.sv
design/wr_burst_merge.sv
design/wlast_rebuild_top.sv
tb/wlast_rebuild_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module wlast_rebuild_tb -f wlast_rebuild.f -o wlast_rebuild_sim

./obj_dir/wlast_rebuild_sim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim: testbench reported success"
    exit 0
else
    echo "run_sim: testbench did not report success"
    exit 1
fi

// ==== tb/wlast_rebuild_testdata.hex ====
// Columns: id, addr, len (beats minus one), data base, data-before-address flag
// Beat k of a burst carries data base plus k with all strobes set
0 00001000 00 a0000000 0
1 00002000 00 a1000000 0
2 00003000 00 a2000000 0
3 00004000 00 a3000000 0
4 00005000 03 b4000000 0
5 00006000 07 b5000000 0
6 00007000 0f b6000000 0
7 00008000 01 b7000000 0
1 00009000 02 c1000000 0
5 0000a000 04 c5000000 0
9 0000b000 00 c9000000 0
d 0000c000 05 cd000000 0
2 0000d000 03 d2000000 1
3 0000e000 00 d3000000 1
8 0000f000 0f d8000000 0
c 00010000 06 dc000000 1
a 00011000 02 da000000 0
e 00012000 0a de000000 0
f 00013000 01 df000000 1
b 00014000 05 db000000 0
0 00015000 0c e0000000 0
4 00016000 00 e4000000 1
6 00017000 03 e6000000 0
1 00018000 0f e1000000 1
7 00019000 02 e7000000 0
5 0001a000 00 e5000000 0
2 0001b000 09 e2000000 0
3 0001c000 04 e3000000 0
